// File: sources.f
+incdir+testbench
verilog/loopFilterPkg.sv
verilog/loopTermsIf.sv
verilog/errorGainStage.sv
verilog/sweepController.sv
verilog/lagIntegrator.sv
verilog/loopOutputStage.sv
verilog/carrierLoopFilter.sv
testbench/loopFilterTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= loopFilterTb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= sources.f
VFLAGS ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard testbench/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/loopFilterModel.svh
`ifndef LOOP_FILTER_MODEL_SVH
`define LOOP_FILTER_MODEL_SVH

localparam int stOff = 0;
localparam int stUp = 1;
localparam int stDown = 2;

typedef struct {
    logic signed [39:0] leadTerm;
    logic signed [39:0] lagTerm;
    logic signed [39:0] leadDelay;
    logic signed [39:0] acc;
    logic signed [39:0] filterOut;
    logic signed [31:0] offset;
    logic hitUpper;
    logic hitLower;
    int sweepState;
    logic sweepingUp;
} modelState_t;

// Gain by exponent: 0 blocks, 1 and 2 divide, 3 is unity, each step above doubles
function automatic logic signed [39:0] gainTerm(logic signed [11:0] e, logic [4:0] x);
    logic signed [39:0] v;
    v = 40'(e);
    if (x == 5'd0) begin
        v = '0;
    end else if (x == 5'd1) begin
        v = v >>> 2;
    end else if (x == 5'd2) begin
        v = v >>> 1;
    end else begin
        for (int i = 3; i < int'(x); i++) begin
            v = v + v;
        end
    end
    return v;
endfunction

function automatic modelState_t resetModel();
    modelState_t s;
    s.leadTerm = '0;
    s.lagTerm = '0;
    s.leadDelay = '0;
    s.acc = '0;
    s.filterOut = '0;
    s.offset = '0;
    s.hitUpper = 1'b0;
    s.hitLower = 1'b0;
    s.sweepState = stOff;
    s.sweepingUp = 1'b1;
    return s;
endfunction

// One clock edge of the loop filter
function automatic modelState_t stepModel(modelState_t s, logic en, logic clr,
        logic signed [11:0] err, logic [4:0] leadE, logic [4:0] lagE,
        logic signed [31:0] up, logic signed [31:0] lo, logic swEn,
        logic signed [31:0] rate, logic inSync);
    modelState_t n;
    logic signed [39:0] sum;
    logic signed [31:0] top;
    n = s;
    if (en) begin
        n.leadTerm = gainTerm(err, leadE);
        n.lagTerm = gainTerm(err, lagE);
        n.leadDelay = s.leadTerm;
        n.filterOut = s.acc + s.leadDelay;
        sum = s.acc + s.lagTerm + {{8{s.offset[31]}}, s.offset};
        top = sum[39:8];
        n.hitUpper = 1'b0;
        n.hitLower = 1'b0;
        if (up < lo) begin
            n.acc = s.acc;
        end else if (top >= up) begin
            n.acc = {up, 8'h00};
            n.hitUpper = 1'b1;
        end else if (top <= lo) begin
            n.acc = {lo, 8'hff};
            n.hitLower = 1'b1;
        end else begin
            n.acc = sum;
        end
        n.offset = '0;
        if (!swEn) begin
            n.sweepState = stOff;
            n.sweepingUp = 1'b1;
        end else if (s.sweepState == stOff) begin
            if (!inSync) begin
                n.sweepState = s.sweepingUp ? stUp : stDown;
                n.offset = s.sweepingUp ? rate : -rate;
            end
        end else if (inSync) begin
            n.sweepingUp = (s.sweepState == stUp);
            n.sweepState = stOff;
        end else if (s.sweepState == stUp) begin
            n.sweepState = s.hitUpper ? stDown : stUp;
            n.offset = s.hitUpper ? -rate : rate;
        end else begin
            n.sweepState = s.hitLower ? stUp : stDown;
            n.offset = s.hitLower ? rate : -rate;
        end
    end
    if (clr) begin
        n.acc = '0;
        n.hitUpper = 1'b0;
        n.hitLower = 1'b0;
    end
    return n;
endfunction

task automatic checkValue(input string name, input logic [39:0] expected,
        input logic [39:0] actual);
    checkCount++;
    if (expected !== actual) begin
        errorCount++;
        $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

// Waits a number of rising edges, bounded by a cycle limit
task automatic waitCycles(input int n);
    int count;
    count = 0;
    while (count < n && count < 100000) begin
        @(posedge clk);
        count++;
    end
    #2;
    if (count < n) begin
        errorCount++;
        $display("Timed out while waiting for %0d cycles", n);
    end
endtask

`endif

// File: testbench/loopFilterTb.sv
`timescale 1ns/10ps

module loopFilterTb;
    logic clk;
    logic reset;
    logic clkEn;
    logic signed [11:0] error;
    logic [4:0] leadExp;
    logic [4:0] lagExp;
    logic signed [31:0] upperLimit;
    logic signed [31:0] lowerLimit;
    logic sweepEnable;
    logic [31:0] sweepRateMag;
    logic carrierInSync;
    logic clearAccum;
    logic signed [39:0] lagAccum;
    logic [31:0] freqWord;

    int errorCount = 0;
    int checkCount = 0;
    int seed = 24943;

    `include "loopFilterModel.svh"

    modelState_t model;

    carrierLoopFilter dut_i (
        .clk(clk), .reset(reset), .clkEn(clkEn), .error(error),
        .leadExp(leadExp), .lagExp(lagExp), .upperLimit(upperLimit),
        .lowerLimit(lowerLimit), .sweepEnable(sweepEnable),
        .sweepRateMag(sweepRateMag), .carrierInSync(carrierInSync),
        .clearAccum(clearAccum), .lagAccum(lagAccum), .freqWord(freqWord)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            model = resetModel();
        end else begin
            model = stepModel(model, clkEn, clearAccum, error, leadExp, lagExp, upperLimit,
                lowerLimit, sweepEnable, signed'(sweepRateMag), carrierInSync);
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            checkValue("lagAccum", model.acc, lagAccum);
            checkValue("freqWord", {8'h00, model.filterOut[39:8]}, {8'h00, freqWord});
        end
    end

    task automatic waitForAccum(input logic [39:0] target, input int limit,
            input string what);
        int n;
        n = 0;
        while (lagAccum !== target && n < limit) begin
            waitCycles(1);
            n++;
        end
        if (lagAccum !== target) begin
            errorCount++;
            $display("Accumulator never reached the %s value", what);
        end
    endtask

    task automatic finishTest(input string name);
        $display("Test %s finished, %0d errors so far", name, errorCount);
    endtask

    initial begin
        logic signed [39:0] held;
        logic [31:0] heldWord;
        int rnd;
        reset = 1'b1;
        clkEn = 1'b1;
        error = '0;
        leadExp = '0;
        lagExp = '0;
        upperLimit = 32'sh4000_0000;
        lowerLimit = -32'sh4000_0000;
        sweepEnable = 1'b0;
        sweepRateMag = '0;
        carrierInSync = 1'b0;
        clearAccum = 1'b0;
        waitCycles(5);
        reset = 1'b0;

        error = 12'sd37;
        for (int x = 0; x < 32; x++) begin
            lagExp = 5'(x);
            leadExp = 5'(x) ^ 5'h0a;
            clearAccum = 1'b1;
            waitCycles(1);
            clearAccum = 1'b0;
            waitCycles(6);
        end
        finishTest("gain scaling");

        upperLimit = 32'sd1000;
        lowerLimit = -32'sd1000;
        lagExp = 5'd10;
        leadExp = 5'd3;
        error = 12'sd2047;
        waitForAccum({32'sd1000, 8'h00}, 50, "upper");
        error = -12'sd2048;
        waitForAccum({-32'sd1000, 8'hff}, 50, "lower");
        upperLimit = -32'sd5;
        lowerLimit = 32'sd5;
        waitCycles(1);
        held = lagAccum;
        waitCycles(5);
        checkValue("lagAccum", held, lagAccum);
        finishTest("clamping");

        error = '0;
        lagExp = '0;
        upperLimit = 32'sd2000;
        lowerLimit = -32'sd2000;
        sweepRateMag = 32'd100000;
        sweepEnable = 1'b1;
        waitForAccum({32'sd2000, 8'h00}, 40, "upper sweep");
        waitForAccum({-32'sd2000, 8'hff}, 40, "lower sweep");
        waitForAccum({32'sd2000, 8'h00}, 40, "upper sweep");
        finishTest("sweep");

        waitCycles(3);
        carrierInSync = 1'b1;
        waitCycles(3);
        held = lagAccum;
        waitCycles(3);
        checkValue("lagAccum", held, lagAccum);
        carrierInSync = 1'b0;
        waitCycles(3);
        if (lagAccum >= held) begin
            errorCount++;
            $display("Sweep did not resume downward after sync was released");
        end
        sweepEnable = 1'b0;
        waitCycles(2);
        held = lagAccum;
        sweepEnable = 1'b1;
        waitCycles(4);
        if (lagAccum <= held) begin
            errorCount++;
            $display("Sweep did not restart upward after being disabled");
        end
        finishTest("sync");

        sweepEnable = 1'b0;
        error = 12'sd300;
        lagExp = 5'd4;
        waitCycles(4);
        clkEn = 1'b0;
        held = lagAccum;
        heldWord = freqWord;
        waitCycles(5);
        checkValue("lagAccum", held, lagAccum);
        checkValue("freqWord", {8'h00, heldWord}, {8'h00, freqWord});
        clearAccum = 1'b1;
        waitCycles(1);
        clearAccum = 1'b0;
        checkValue("lagAccum", 40'h0, lagAccum);
        checkValue("freqWord", {8'h00, heldWord}, {8'h00, freqWord});
        clkEn = 1'b1;
        finishTest("strobe and clear");

        upperLimit = 32'sh0010_0000;
        lowerLimit = -32'sh0010_0000;
        sweepRateMag = 32'd5000;
        for (int i = 0; i < 2000; i++) begin
            rnd = $random(seed);
            error = rnd[11:0];
            leadExp = rnd[16:12];
            lagExp = 5'(rnd[20:17] % 12);
            clkEn = (rnd[22:21] != 2'b00);
            carrierInSync = (rnd[25:23] == 3'b000);
            clearAccum = (rnd[31:26] == 6'd0);
            if (rnd[7:0] == 8'd1) begin
                sweepEnable = ~sweepEnable;
            end
            waitCycles(1);
        end
        clkEn = 1'b1;
        clearAccum = 1'b0;
        waitCycles(2);
        finishTest("random run");

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #2000000;
        $display("Simulation did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

// File: verilog/carrierLoopFilter.sv
`timescale 1ns/10ps

module carrierLoopFilter (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  logic signed [loopFilterPkg::errW-1:0] error,
    input  logic [loopFilterPkg::expW-1:0] leadExp,
    input  logic [loopFilterPkg::expW-1:0] lagExp,
    input  logic signed [loopFilterPkg::limitW-1:0] upperLimit,
    input  logic signed [loopFilterPkg::limitW-1:0] lowerLimit,
    input  logic sweepEnable,
    input  logic [loopFilterPkg::limitW-1:0] sweepRateMag,
    input  logic carrierInSync,
    input  logic clearAccum,
    output logic signed [loopFilterPkg::accW-1:0] lagAccum,
    output logic [loopFilterPkg::limitW-1:0] freqWord
);

    loopTermsIf termsIf (.clk(clk));

    errorGainStage gain_i (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .error(error),
        .leadExp(leadExp),
        .lagExp(lagExp),
        .terms(termsIf.gainSrc)
    );

    sweepController sweep_i (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .sweepEnable(sweepEnable),
        .carrierInSync(carrierInSync),
        .sweepRateMag(sweepRateMag),
        .terms(termsIf.sweepSrc)
    );

    lagIntegrator integ_i (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .clearAccum(clearAccum),
        .upperLimit(upperLimit),
        .lowerLimit(lowerLimit),
        .terms(termsIf.integ),
        .lagAccum(lagAccum)
    );

    loopOutputStage out_i (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .terms(termsIf.sumSink),
        .lagAccum(lagAccum),
        .freqWord(freqWord)
    );

endmodule

// File: verilog/loopOutputStage.sv
`timescale 1ns/10ps

module loopOutputStage (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    loopTermsIf.sumSink terms,
    input  logic signed [loopFilterPkg::accW-1:0] lagAccum,
    output logic [loopFilterPkg::limitW-1:0] freqWord
);
    import loopFilterPkg::*;

    logic signed [accW-1:0] leadDelay;
    logic signed [accW-1:0] filterOut;
    logic signed [accW-1:0] filterNext;

    // The integrator lags the gain stage by one strobe, so the lead path does too
    assign filterNext = lagAccum + leadDelay;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leadDelay <= '0;
            filterOut <= '0;
        end else if (clkEn) begin
            leadDelay <= terms.leadTerm;
            filterOut <= filterNext;
        end
    end

    // Integer part only, wrapping in two's complement
    assign freqWord = filterOut[accW-1:fracW];

endmodule

// File: verilog/lagIntegrator.sv
`timescale 1ns/10ps

module lagIntegrator (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  logic clearAccum,
    input  logic signed [loopFilterPkg::limitW-1:0] upperLimit,
    input  logic signed [loopFilterPkg::limitW-1:0] lowerLimit,
    loopTermsIf.integ terms,
    output logic signed [loopFilterPkg::accW-1:0] lagAccum
);
    import loopFilterPkg::*;

    logic signed [accW-1:0] offsetExt;
    logic signed [accW-1:0] sum;
    logic signed [limitW-1:0] sumTop;
    logic signed [limitW-1:0] accTop;
    logic signed [accW-1:0] upperValue;
    logic signed [accW-1:0] lowerValue;
    logic limitsInverted;
    logic signed [accW-1:0] accumNext;
    logic upperNext;
    logic lowerNext;

    assign offsetExt = {{(accW-limitW){terms.sweepOffset[limitW-1]}}, terms.sweepOffset};
    assign sum = lagAccum + terms.lagTerm + offsetExt;
    assign sumTop = sum[accW-1:fracW];
    assign accTop = lagAccum[accW-1:fracW];

    // Clamp values sit at the extreme fraction of each limit
    assign upperValue = {upperLimit, {fracW{1'b0}}};
    assign lowerValue = {lowerLimit, {fracW{1'b1}}};
    assign limitsInverted = upperLimit < lowerLimit;

    always_comb begin
        if (limitsInverted) begin
            // Nonsense limits freeze the loop
            accumNext = lagAccum;
            upperNext = 1'b0;
            lowerNext = 1'b0;
        end else if (sumTop >= upperLimit) begin
            accumNext = upperValue;
            upperNext = 1'b1;
            lowerNext = 1'b0;
        end else if (sumTop <= lowerLimit) begin
            accumNext = lowerValue;
            upperNext = 1'b0;
            lowerNext = 1'b1;
        end else begin
            accumNext = sum;
            upperNext = 1'b0;
            lowerNext = 1'b0;
        end
    end

    // Clear acts on any edge, independent of the strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum <= '0;
            terms.hitUpper <= 1'b0;
            terms.hitLower <= 1'b0;
        end else if (clearAccum) begin
            lagAccum <= '0;
            terms.hitUpper <= 1'b0;
            terms.hitLower <= 1'b0;
        end else if (clkEn) begin
            lagAccum <= accumNext;
            terms.hitUpper <= upperNext;
            terms.hitLower <= lowerNext;
        end
    end

    assertOneFlag: assert property (
        @(posedge clk) disable iff (reset)
            !(terms.hitUpper && terms.hitLower)
    ) else $error("Both limit flags set");

    property accumWithinLimits;
        @(posedge clk) disable iff (reset)
            (clkEn && !clearAccum && !limitsInverted) |=>
                ((accTop <= $past(upperLimit)) && (accTop >= $past(lowerLimit)));
    endproperty

    assertWithinLimits: assert property (accumWithinLimits)
        else $error("Accumulator outside limits after a strobe");

endmodule

// File: verilog/sweepController.sv
`timescale 1ns/10ps

module sweepController (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  logic sweepEnable,
    input  logic carrierInSync,
    input  logic [loopFilterPkg::limitW-1:0] sweepRateMag,
    loopTermsIf.sweepSrc terms
);
    import loopFilterPkg::*;

    sweepState_t sweepState;
    sweepState_t stateNext;
    logic sweepingUp;
    logic sweepingUpNext;
    logic signed [limitW-1:0] offsetNext;
    logic signed [limitW-1:0] posRate;
    logic signed [limitW-1:0] negRate;

    assign posRate = signed'(sweepRateMag);
    assign negRate = -posRate;

    always_comb begin
        stateNext = sweepState;
        sweepingUpNext = sweepingUp;
        offsetNext = '0;
        if (!sweepEnable) begin
            stateNext = sweepOff;
            sweepingUpNext = 1'b1;
        end else begin
            case (sweepState)
                sweepOff: begin
                    // Restart in the direction last swept
                    if (!carrierInSync) begin
                        if (sweepingUp) begin
                            stateNext = sweepUp;
                            offsetNext = posRate;
                        end else begin
                            stateNext = sweepDown;
                            offsetNext = negRate;
                        end
                    end
                end
                sweepUp: begin
                    if (carrierInSync) begin
                        stateNext = sweepOff;
                        sweepingUpNext = 1'b1;
                    end else if (terms.hitUpper) begin
                        stateNext = sweepDown;
                        offsetNext = negRate;
                    end else begin
                        offsetNext = posRate;
                    end
                end
                sweepDown: begin
                    if (carrierInSync) begin
                        stateNext = sweepOff;
                        sweepingUpNext = 1'b0;
                    end else if (terms.hitLower) begin
                        stateNext = sweepUp;
                        offsetNext = posRate;
                    end else begin
                        offsetNext = negRate;
                    end
                end
                default: begin
                    stateNext = sweepOff;
                    sweepingUpNext = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sweepState <= sweepOff;
            sweepingUp <= 1'b1;
            terms.sweepOffset <= '0;
        end else if (clkEn) begin
            sweepState <= stateNext;
            sweepingUp <= sweepingUpNext;
            terms.sweepOffset <= offsetNext;
        end
    end

    assertIdleOffset: assert property (
        @(posedge clk) disable iff (reset)
            (sweepState == sweepOff) |-> (terms.sweepOffset == '0)
    ) else $error("Nonzero sweep offset while sweep is off");

endmodule

// File: verilog/errorGainStage.sv
`timescale 1ns/10ps

module errorGainStage (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  logic signed [loopFilterPkg::errW-1:0] error,
    input  logic [loopFilterPkg::expW-1:0] leadExp,
    input  logic [loopFilterPkg::expW-1:0] lagExp,
    loopTermsIf.gainSrc terms
);
    import loopFilterPkg::*;

    logic signed [accW-1:0] leadNext;
    logic signed [accW-1:0] lagNext;

    // Both paths share the same shifter definition
    always_comb begin
        leadNext = scaleError(error, leadExp);
        lagNext = scaleError(error, lagExp);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            terms.leadTerm <= '0;
            terms.lagTerm <= '0;
        end else if (clkEn) begin
            terms.leadTerm <= leadNext;
            terms.lagTerm <= lagNext;
        end
    end

    // Downstream stages rely on the terms holding between strobes
    property termsHoldWithoutStrobe;
        @(posedge clk) disable iff (reset)
            !clkEn |=> ($stable(terms.leadTerm) && $stable(terms.lagTerm));
    endproperty

    assertTermsHold: assert property (termsHoldWithoutStrobe)
        else $error("Gain terms changed without a strobe");

endmodule

// File: verilog/loopTermsIf.sv
`timescale 1ns/10ps

interface loopTermsIf (
    input logic clk
);
    import loopFilterPkg::*;

    logic signed [accW-1:0] leadTerm;
    logic signed [accW-1:0] lagTerm;
    logic signed [limitW-1:0] sweepOffset;
    logic hitUpper;
    logic hitLower;

    modport gainSrc (
        input  clk,
        output leadTerm,
        output lagTerm
    );

    modport sweepSrc (
        input  clk,
        output sweepOffset,
        input  hitUpper,
        input  hitLower
    );

    modport integ (
        input  clk,
        input  lagTerm,
        input  sweepOffset,
        output hitUpper,
        output hitLower
    );

    modport sumSink (
        input  clk,
        input  leadTerm
    );

endinterface

// File: verilog/loopFilterPkg.sv
package loopFilterPkg;

    // Phase error and gain exponent widths
    localparam int errW = 12;
    localparam int expW = 5;

    // Accumulator and gain terms, with a binary point above the fraction bits
    localparam int accW = 40;
    localparam int fracW = 8;

    // Limits, sweep rate, sweep offset and NCO frequency word
    localparam int limitW = 32;

    typedef enum logic [1:0] {
        sweepOff,
        sweepUp,
        sweepDown
    } sweepState_t;

    // Power-of-two gain applied to the phase error
    // Exponent 3 is unity gain, exponents 1 and 2 are fractional, 0 blocks the error
    function automatic logic signed [accW-1:0] scaleError(
        input logic signed [errW-1:0] err,
        input logic [expW-1:0] gainExp
    );
        logic signed [accW-1:0] extended;
        logic signed [accW-1:0] scaled;

        extended = {{(accW-errW){err[errW-1]}}, err};
        case (gainExp)
            5'd0: begin
                scaled = '0;
            end
            5'd1: begin
                scaled = extended >>> 2;
            end
            5'd2: begin
                scaled = extended >>> 1;
            end
            default: begin
                scaled = extended <<< (gainExp - 3);
            end
        endcase
        return scaled;
    endfunction

endpackage
